//--- hw/rename_pkg.sv
// shared rename types; sizes fixed at 32 arch regs, 64 tags, 8 checkpoint slots
`default_nettype none

package rename_pkg;

  // machine sizes
  localparam int num_arch = 32;
  localparam int num_phys = 64;
  localparam int num_ckpt = 8;

  // architectural register index
  typedef logic [4:0] arch_idx_t;
  // physical register tag
  typedef logic [5:0] phys_tag_t;
  // checkpoint slot index
  typedef logic [2:0] ckpt_idx_t;

  // one map slot, tag plus ready
  typedef struct packed {
    phys_tag_t tag;
    logic      ready;
  } map_entry_t;

  // whole map, indexed by arch reg
  typedef map_entry_t [num_arch-1:0] map_t;

  // queue pointer, msb is the wrap bit
  typedef logic [6:0] free_ptr_t;

  // free list starts with tags 32..63 queued
  localparam free_ptr_t free_init_head = '0;
  localparam free_ptr_t free_init_tail = free_ptr_t'(num_phys - num_arch);

  // arch reg i sits on tag i, ready
  function automatic map_t reset_map();
    map_t m;
    for (int i = 0; i < num_arch; i++) begin
      m[i] = '{tag: phys_tag_t'(i), ready: 1'b1};
    end
    return m;
  endfunction

  // queue slot i holds tag i+32 at reset; upper half wraps and is never read
  function automatic phys_tag_t free_reset_tag(int i);
    return phys_tag_t'(i + num_arch);
  endfunction

endpackage

`default_nettype wire

//--- hw/map_port_if.sv
// controller to map table link; lookups are combinational, write commits on the edge
`timescale 1ns/10ps
`default_nettype none

interface map_port_if import rename_pkg::*; ();

  // request side
  arch_idx_t  src_a;
  arch_idx_t  src_b;
  arch_idx_t  dest;
  phys_tag_t  new_tag;
  logic       write;
  logic       ckpt_save;
  ckpt_idx_t  ckpt_slot;

  // lookup results
  map_entry_t src_a_entry;
  map_entry_t src_b_entry;
  phys_tag_t  told;

  // rename controller end
  modport ctrl (
    output src_a, src_b, dest, new_tag, write, ckpt_save, ckpt_slot,
    input  src_a_entry, src_b_entry, told
  );

  // map table end
  modport tbl (
    input  src_a, src_b, dest, new_tag, write, ckpt_save, ckpt_slot,
    output src_a_entry, src_b_entry, told
  );

endinterface

`default_nettype wire

//--- hw/map_table.sv
// map table; arch reg 0 is forced to tag 0 ready, rollback wins over a same-cycle commit
`timescale 1ns/10ps
`default_nettype none

module map_table import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  map_port_if.tbl   port,
  input  logic      complete_valid,
  input  phys_tag_t complete_tag,
  input  logic      rollback_valid,
  input  ckpt_idx_t rollback_slot
);

  // live map and saved copies
  map_t       map_q;
  map_t       ckpt_q [num_ckpt];

  // map with this cycle's completion folded in
  map_t       map_woken;
  // map for the next edge
  map_t       map_next;

  // told comes from the map before any write
  map_entry_t told_entry;

  // snapshot form, every tag treated as ready
  function automatic map_t set_all_ready(map_t m);
    map_t r;
    r = m;
    for (int i = 0; i < num_arch; i++) begin
      r[i].ready = 1'b1;
    end
    return r;
  endfunction

  // single lookup with the r0 hardwire
  function automatic map_entry_t read_entry(map_t m, arch_idx_t r);
    map_entry_t e;
    e = m[r];
    if (r == '0) begin
      e = '{tag: '0, ready: 1'b1};
    end
    return e;
  endfunction

  // completion wake-up
  // every entry holding the completed tag goes ready
  always_comb begin
    map_woken = map_q;
    if (complete_valid) begin
      for (int i = 0; i < num_arch; i++) begin
        if (map_q[i].tag == complete_tag) begin
          map_woken[i].ready = 1'b1;
        end
      end
    end
  end

  // source lookups bypass the completion on this edge
  assign port.src_a_entry = read_entry(map_woken, port.src_a);
  assign port.src_b_entry = read_entry(map_woken, port.src_b);

  // old mapping of the destination
  assign told_entry = read_entry(map_q, port.dest);
  assign port.told  = told_entry.tag;

  // next-state map
  always_comb begin
    if (rollback_valid) begin
      // restore the saved map as a whole
      map_next = ckpt_q[rollback_slot];
    end else begin
      map_next = map_woken;
      // new tag starts not ready; r0 is never remapped
      if (port.write && port.dest != '0) begin
        map_next[port.dest] = '{tag: port.new_tag, ready: 1'b0};
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      map_q <= reset_map();
      for (int s = 0; s < num_ckpt; s++) begin
        ckpt_q[s] <= reset_map();
      end
    end else begin
      map_q <= map_next;
      // checkpoint holds the post-write map, all ready
      if (port.ckpt_save && !rollback_valid) begin
        ckpt_q[port.ckpt_slot] <= set_all_ready(map_next);
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/free_list.sv
// free tag queue; push into a full queue and pop of an empty one are not guarded
`timescale 1ns/10ps
`default_nettype none

module free_list import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      pop,
  output phys_tag_t head_tag,
  output logic      empty,
  input  logic      push,
  input  phys_tag_t push_tag,
  input  logic      ckpt_save,
  input  ckpt_idx_t ckpt_slot,
  input  logic      rollback_valid,
  input  ckpt_idx_t rollback_slot
);

  localparam int idx_w = $bits(phys_tag_t);

  // tag storage, indexed by pointer low bits
  phys_tag_t mem [num_phys];

  // head and tail, wrap bit on top
  free_ptr_t head_q;
  free_ptr_t tail_q;
  free_ptr_t head_next;

  // saved head per checkpoint slot
  free_ptr_t ckpt_head [num_ckpt];

  // same index and same wrap means nothing queued
  assign empty    = (head_q == tail_q);
  assign head_tag = mem[head_q[idx_w-1:0]];

  // head after this cycle's pop
  assign head_next = pop ? head_q + 1'b1 : head_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q <= free_init_head;
      tail_q <= free_init_tail;
      for (int i = 0; i < num_phys; i++) begin
        mem[i] <= free_reset_tag(i);
      end
      for (int s = 0; s < num_ckpt; s++) begin
        ckpt_head[s] <= free_init_head;
      end
    end else begin
      // retired tags enter at the tail
      if (push) begin
        mem[tail_q[idx_w-1:0]] <= push_tag;
        tail_q                 <= tail_q + 1'b1;
      end
      // rollback rewinds the head
      // speculative tags past it become free again
      if (rollback_valid) begin
        head_q <= ckpt_head[rollback_slot];
      end else begin
        head_q <= head_next;
        if (ckpt_save) begin
          ckpt_head[ckpt_slot] <= head_next;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/rename_ctrl.sv
// rename handshake; one rename in flight, acceptance stalls only on an empty free list
`timescale 1ns/10ps
`default_nettype none

module rename_ctrl import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      req,
  input  arch_idx_t src_a,
  input  arch_idx_t src_b,
  input  arch_idx_t dest,
  input  logic      ckpt_save,
  input  ckpt_idx_t ckpt_slot,
  input  logic      rollback_valid,
  map_port_if.ctrl  map,
  input  phys_tag_t head_tag,
  input  logic      empty,
  output logic      pop,
  output logic      ack,
  output phys_tag_t t1,
  output phys_tag_t t2,
  output phys_tag_t told,
  output phys_tag_t new_tag,
  output logic      t1_ready,
  output logic      t2_ready
);

  // four-phase state
  typedef enum logic {
    st_idle,
    st_done
  } state_t;

  state_t state_q;
  logic   accept;
  logic   dest_zero;

  // r0 destination needs no free tag
  assign dest_zero = (dest == '0);

  // take the rename on this edge
  // rollback blocks it for one cycle
  assign accept = req && (state_q == st_idle) && !rollback_valid &&
                  (!empty || dest_zero);

  // request fields straight to the map
  assign map.src_a     = src_a;
  assign map.src_b     = src_b;
  assign map.dest      = dest;
  assign map.new_tag   = dest_zero ? '0 : head_tag;
  assign map.write     = accept;
  assign map.ckpt_save = accept && ckpt_save;
  assign map.ckpt_slot = ckpt_slot;

  // no allocation for r0
  assign pop = accept && !dest_zero;

  assign ack = (state_q == st_done);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= st_idle;
    end else if (accept) begin
      state_q <= st_done;
    end else if (state_q == st_done && !req) begin
      // requester has let go, close the handshake
      state_q <= st_idle;
    end
  end

  // response held for the whole ack phase
  always_ff @(posedge clock) begin
    if (accept) begin
      t1       <= map.src_a_entry.tag;
      t1_ready <= map.src_a_entry.ready;
      t2       <= map.src_b_entry.tag;
      t2_ready <= map.src_b_entry.ready;
      told     <= map.told;
      new_tag  <= map.new_tag;
    end
  end

endmodule

`default_nettype wire

//--- hw/rename_top.sv
// rename stage top; inputs are sampled on the rising clock, response valid while ack
`timescale 1ns/10ps
`default_nettype none

module rename_top import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  // rename request
  input  logic      req,
  input  arch_idx_t src_a,
  input  arch_idx_t src_b,
  input  arch_idx_t dest,
  input  logic      ckpt_save,
  input  ckpt_idx_t ckpt_slot,
  // rename response
  output logic      ack,
  output phys_tag_t t1,
  output logic      t1_ready,
  output phys_tag_t t2,
  output logic      t2_ready,
  output phys_tag_t told,
  output phys_tag_t new_tag,
  // completion bus
  input  logic      complete_valid,
  input  phys_tag_t complete_tag,
  // retirement
  input  logic      retire_valid,
  input  phys_tag_t retire_tag,
  // rollback
  input  logic      rollback_valid,
  input  ckpt_idx_t rollback_slot
);

  map_port_if map_if ();

  // free list handshake
  phys_tag_t head_tag;
  logic      empty;
  logic      pop;

  map_table u_map_table (
    .clock          (clock),
    .reset          (reset),
    .port           (map_if.tbl),
    .complete_valid (complete_valid),
    .complete_tag   (complete_tag),
    .rollback_valid (rollback_valid),
    .rollback_slot  (rollback_slot)
  );

  // checkpoint strobe is the gated one from the controller
  free_list u_free_list (
    .clock          (clock),
    .reset          (reset),
    .pop            (pop),
    .head_tag       (head_tag),
    .empty          (empty),
    .push           (retire_valid),
    .push_tag       (retire_tag),
    .ckpt_save      (map_if.ckpt_save),
    .ckpt_slot      (map_if.ckpt_slot),
    .rollback_valid (rollback_valid),
    .rollback_slot  (rollback_slot)
  );

  rename_ctrl u_rename_ctrl (
    .clock          (clock),
    .reset          (reset),
    .req            (req),
    .src_a          (src_a),
    .src_b          (src_b),
    .dest           (dest),
    .ckpt_save      (ckpt_save),
    .ckpt_slot      (ckpt_slot),
    .rollback_valid (rollback_valid),
    .map            (map_if.ctrl),
    .head_tag       (head_tag),
    .empty          (empty),
    .pop            (pop),
    .ack            (ack),
    .t1             (t1),
    .t2             (t2),
    .told           (told),
    .new_tag        (new_tag),
    .t1_ready       (t1_ready),
    .t2_ready       (t2_ready)
  );

endmodule

`default_nettype wire

//--- verif/rename_chk.sv
// handshake and allocation assertions for rename_top; tag check covers only the first 32 renames
`timescale 1ns/10ps
`default_nettype none

module rename_chk import rename_pkg::*; (
  input logic      clock,
  input logic      reset,
  input logic      req,
  input logic      ack,
  input arch_idx_t dest,
  input phys_tag_t new_tag
);

  logic        ack_q;
  // completed handshakes so far
  int unsigned renames;

  always @(posedge clock) begin
    if (reset) begin
      ack_q   <= 1'b0;
      renames <= 0;
    end else begin
      ack_q <= ack;
      if (ack && !ack_q) begin
        renames <= renames + 1;
      end
    end
  end

  // ack only answers a raised request
  ack_needs_req: assert property (@(posedge clock) disable iff (reset)
    $rose(ack) |-> $past(req))
    else $error("ack rose without a request");

  // requester holds req until ack is up
  req_held: assert property (@(posedge clock) disable iff (reset)
    $fell(req) |-> ack)
    else $error("req dropped before ack");

  // initial pool holds only tags 32..63
  fresh_tag: assert property (@(posedge clock) disable iff (reset)
    ($rose(ack) && dest != '0 && renames < 32) |-> new_tag >= 6'd32)
    else $error("new tag below 32 while the initial pool lasts");

endmodule

bind rename_top rename_chk u_chk (
  .clock   (clock),
  .reset   (reset),
  .req     (req),
  .ack     (ack),
  .dest    (dest),
  .new_tag (new_tag)
);

`default_nettype wire

//--- verif/rename_monitor.sv
// response checker; compares the response at each rising ack with the expected word from the testbench
`timescale 1ns/10ps
`default_nettype none

module rename_monitor import rename_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        ack,
  input  phys_tag_t   t1,
  input  logic        t1_ready,
  input  phys_tag_t   t2,
  input  logic        t2_ready,
  input  phys_tag_t   told,
  input  phys_tag_t   new_tag,
  // {t1, t1_ready, t2, t2_ready, told, new_tag}
  input  logic [25:0] exp_resp,
  input  logic [95:0] test_name,
  output int          checked,
  output int          mismatches
);

  logic        ack_q;
  logic [25:0] got;

  assign got = {t1, t1_ready, t2, t2_ready, told, new_tag};

  // readable form of a response word
  function automatic string show(logic [25:0] r);
    return $sformatf("t1=%0d/%0b t2=%0d/%0b told=%0d new=%0d",
                     r[25:20], r[19], r[18:13], r[12], r[11:6], r[5:0]);
  endfunction

  // response is stable for the whole ack phase
  always @(posedge clock) begin
    if (reset) begin
      ack_q      <= 1'b0;
      checked    <= 0;
      mismatches <= 0;
    end else begin
      ack_q <= ack;
      if (ack && !ack_q) begin
        checked <= checked + 1;
        if (got !== exp_resp) begin
          mismatches <= mismatches + 1;
          $display("mismatch %0s: expected %s, actual %s", test_name, show(exp_resp), show(got));
        end else begin
          $display("%0s: ok, %s", test_name, show(got));
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/rename_tb.sv
// rename stage testbench; fixed operation table, one rename in flight, no random stimulus
`timescale 1ns/10ps
`default_nettype none

module rename_tb import rename_pkg::*; ();

  localparam int wait_limit = 50;
  localparam logic [1:0] k_rename   = 2'd0;
  localparam logic [1:0] k_complete = 2'd1;
  localparam logic [1:0] k_retire   = 2'd2;
  localparam logic [1:0] k_rollback = 2'd3;

  // one table row
  typedef struct packed {
    logic [1:0]  kind;
    logic [95:0] name;
    arch_idx_t   a;
    arch_idx_t   b;
    arch_idx_t   d;
    logic        save;
    ckpt_idx_t   slot;
    logic        cvalid;
    phys_tag_t   tag;
    logic [3:0]  stall;
    phys_tag_t   rtag;
    logic [25:0] exp;
  } op_t;

  logic clock = 1'b0;
  logic reset = 1'b1;
  logic req, ckpt_save, ack, t1_ready, t2_ready;
  logic complete_valid, retire_valid, rollback_valid;
  arch_idx_t src_a, src_b, dest;
  ckpt_idx_t ckpt_slot, rollback_slot;
  phys_tag_t t1, t2, told, new_tag, complete_tag, retire_tag;

  logic [25:0] exp_resp = '0;
  logic [95:0] test_name = '0;
  int checked, mismatches;
  int fails = 0;
  int steps = 0;
  int renames_sent = 0;
  logic aborted = 1'b0;
  op_t ops[$];

  always #4 clock = ~clock;

  rename_top UUT (.*);

  rename_monitor u_monitor (.*);

  // expected response word
  function automatic logic [25:0] resp(phys_tag_t a_tag, logic a_rdy, phys_tag_t b_tag,
                                       logic b_rdy, phys_tag_t old, phys_tag_t nt);
    return {a_tag, a_rdy, b_tag, b_rdy, old, nt};
  endfunction

  function automatic op_t rename_op(logic [95:0] name, arch_idx_t a, arch_idx_t b,
                                    arch_idx_t d, logic [25:0] exp);
    op_t o;
    o = '0;
    o.kind = k_rename;
    o.name = name;
    o.a    = a;
    o.b    = b;
    o.d    = d;
    o.exp  = exp;
    return o;
  endfunction

  function automatic op_t side_op(logic [1:0] kind, logic [95:0] name, phys_tag_t tag,
                                  ckpt_idx_t slot);
    op_t o;
    o = '0;
    o.kind = kind;
    o.name = name;
    o.tag  = tag;
    o.slot = slot;
    return o;
  endfunction

  // expected values follow the reset map and the 32..63 free order
  task automatic build_table();
    op_t o;
    ops.push_back(rename_op("fresh_r1", 5'd1, 5'd2, 5'd3, resp(6'd1, 1, 6'd2, 1, 6'd3, 6'd32)));
    ops.push_back(rename_op("fresh_r2", 5'd3, 5'd4, 5'd5, resp(6'd32, 0, 6'd4, 1, 6'd5, 6'd33)));
    ops.push_back(side_op(k_complete, "complete_32", 6'd32, 3'd0));
    ops.push_back(rename_op("woken_src", 5'd3, 5'd5, 5'd6, resp(6'd32, 1, 6'd33, 0, 6'd6, 6'd34)));
    // completion of 34 lands on the rename edge
    o = rename_op("bypass", 5'd6, 5'd5, 5'd7, resp(6'd34, 1, 6'd33, 0, 6'd7, 6'd35));
    o.cvalid = 1'b1;
    o.tag    = 6'd34;
    ops.push_back(o);
    ops.push_back(rename_op("dest_zero", 5'd0, 5'd6, 5'd0, resp(6'd0, 1, 6'd34, 1, 6'd0, 6'd0)));
    o = rename_op("ckpt_save", 5'd7, 5'd1, 5'd8, resp(6'd35, 0, 6'd1, 1, 6'd8, 6'd36));
    o.save = 1'b1;
    o.slot = 3'd2;
    ops.push_back(o);
    ops.push_back(rename_op("spec1", 5'd8, 5'd3, 5'd5, resp(6'd36, 0, 6'd32, 1, 6'd33, 6'd37)));
    ops.push_back(rename_op("spec2", 5'd5, 5'd9, 5'd8, resp(6'd37, 0, 6'd9, 1, 6'd36, 6'd38)));
    ops.push_back(side_op(k_rollback, "rollback_2", 6'd0, 3'd2));
    // snapshot is all ready, head back at tag 37
    ops.push_back(rename_op("after_rb", 5'd5, 5'd8, 5'd9, resp(6'd33, 1, 6'd36, 1, 6'd9, 6'd37)));
    // drain the rest of the pool through r10
    for (int k = 0; k < 26; k++) begin
      ops.push_back(rename_op("fill", 5'd1, 5'd2, 5'd10,
                              resp(6'd1, 1, 6'd2, 1, (k == 0) ? 6'd10 : phys_tag_t'(37 + k),
                                   phys_tag_t'(38 + k))));
    end
    // pool empty, only the retired tag frees it
    o = rename_op("stall_retire", 5'd10, 5'd9, 5'd11, resp(6'd63, 0, 6'd37, 0, 6'd11, 6'd10));
    o.stall = 4'd4;
    o.rtag  = 6'd10;
    ops.push_back(o);
    ops.push_back(side_op(k_retire, "retire_33", 6'd33, 3'd0));
    ops.push_back(rename_op("reuse", 5'd11, 5'd0, 5'd12, resp(6'd10, 0, 6'd0, 1, 6'd12, 6'd33)));
  endtask

  // four-phase rename, starts and ends on a falling edge
  task automatic do_rename(input op_t o);
    int n;
    test_name      = o.name;
    exp_resp       = o.exp;
    src_a          = o.a;
    src_b          = o.b;
    dest           = o.d;
    ckpt_save      = o.save;
    ckpt_slot      = o.slot;
    complete_valid = o.cvalid;
    complete_tag   = o.tag;
    req            = 1'b1;
    renames_sent++;
    @(negedge clock);
    complete_valid = 1'b0;
    // no ack while the pool is empty
    for (n = 0; n < o.stall; n++) begin
      if (ack) begin
        $display("%0s: ack came while the free list was empty", o.name);
        fails++;
      end
      @(negedge clock);
    end
    if (o.stall != 0) begin
      retire_valid = 1'b1;
      retire_tag   = o.rtag;
      @(negedge clock);
      retire_valid = 1'b0;
    end
    n = 0;
    while (!ack && n < wait_limit) begin
      @(negedge clock);
      n++;
    end
    if (!ack) begin
      $display("%0s: timed out waiting for ack to rise", o.name);
      aborted = 1'b1;
      return;
    end
    req = 1'b0;
    n = 0;
    while (ack && n < wait_limit) begin
      @(negedge clock);
      n++;
    end
    if (ack) begin
      $display("%0s: timed out waiting for ack to fall", o.name);
      aborted = 1'b1;
    end
  endtask

  // one-cycle pulse on a side input while idle
  task automatic do_side(input op_t o);
    case (o.kind)
      k_complete: begin
        complete_valid = 1'b1;
        complete_tag   = o.tag;
      end
      k_retire: begin
        retire_valid = 1'b1;
        retire_tag   = o.tag;
      end
      default: begin
        rollback_valid = 1'b1;
        rollback_slot  = o.slot;
      end
    endcase
    @(negedge clock);
    complete_valid = 1'b0;
    retire_valid   = 1'b0;
    rollback_valid = 1'b0;
    steps++;
    if (ack) begin
      $display("%0s: ack rose with no request pending", o.name);
      fails++;
    end else begin
      $display("%0s: applied, ack stayed low", o.name);
    end
  endtask

  initial begin
    req            = 1'b0;
    src_a          = '0;
    src_b          = '0;
    dest           = '0;
    ckpt_save      = 1'b0;
    ckpt_slot      = '0;
    complete_valid = 1'b0;
    complete_tag   = '0;
    retire_valid   = 1'b0;
    retire_tag     = '0;
    rollback_valid = 1'b0;
    rollback_slot  = '0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    build_table();
    for (int i = 0; i < ops.size(); i++) begin
      if (ops[i].kind == k_rename) begin
        do_rename(ops[i]);
      end else begin
        do_side(ops[i]);
      end
      if (aborted) begin
        break;
      end
    end
    @(negedge clock);
    $display("renames %0d of %0d checked, side steps %0d, mismatches %0d, other failures %0d",
             checked, renames_sent, steps, mismatches, fails);
    if (!aborted && fails == 0 && mismatches == 0 && checked == renames_sent) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
hw/rename_pkg.sv
hw/map_port_if.sv
hw/map_table.sv
hw/free_list.sv
hw/rename_ctrl.sv
hw/rename_top.sv
verif/rename_chk.sv
verif/rename_monitor.sv
verif/rename_tb.sv

//--- Makefile
# Verilator build and run for the rename stage testbench

VERILATOR ?= verilator
TOP       ?= rename_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  := ** FAIL **

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM)

# rebuilt only when a source or the list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a crashed run counts as a failure in the log
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)

check: run
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
